// ==== hdl/mem_pkg.sv ====
package mem_pkg;

   localparam int LINE_WORDS = 16; // 32-bit words per 64-byte line

   // byte address on the memory side
   typedef logic [31:0] addr_t;

   typedef logic [31:0] word_t;

   typedef logic [511:0] line_t;

   // read id on the bus (the pool may use fewer bits)
   typedef logic [7:0] mem_id_t;

   typedef logic [3:0] word_idx_t;  // word position within a line

   typedef logic [15:0] word_mask_t; // one bit per word of a line

   typedef struct packed {
      addr_t   addr;
      mem_id_t id;
   } mem_ar_t;

   typedef struct packed {
      mem_id_t id;
      line_t   data;
   } mem_r_t;

endpackage

// ==== hdl/task_pkg.sv ====
package task_pkg;

   localparam int LOG_THREADS = 2;
   localparam int N_THREADS   = 2**LOG_THREADS;

   typedef logic [LOG_THREADS-1:0] thread_id_t;
   typedef logic [7:0]             task_tag_t;
   typedef logic [6:0]             n_words_t;   // 1 to 64 words

   typedef struct packed {
      task_tag_t      tag;
      mem_pkg::addr_t addr;   // word aligned
      n_words_t       n_words;
   } ro_req_t;

   // per-thread context, written when the thread is taken
   typedef struct packed {
      task_tag_t tag;
      n_words_t  n_words;
   } thread_ctx_t;

   typedef struct packed {
      thread_id_t          thread;
      mem_pkg::word_mask_t valid_words;
      n_words_t            start_word_id; // word_id of the first valid word
   } ro_mshr_t;

   typedef struct packed {
      task_tag_t      tag;
      n_words_t       word_id;
      mem_pkg::word_t data;
      logic           last;
   } out_word_t;

endpackage

// ==== hdl/ro_free_list.sv ====
`timescale 1ns/10ps

module ro_free_list #(
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 push,
   input  logic [LOG_DEPTH-1:0] push_id,
   input  logic                 pop,
   output logic [LOG_DEPTH-1:0] head,
   output logic                 empty,
   output logic                 full
);

   localparam int DEPTH = 2**LOG_DEPTH;

   logic [LOG_DEPTH-1:0] ids [DEPTH];
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH:0]   count;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < DEPTH; i++) begin
            ids[i] <= LOG_DEPTH'(i); // every id starts out free
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= (LOG_DEPTH+1)'(DEPTH);
      end else begin
         if (push) begin
            ids[wr_ptr] <= push_id;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop) count <= count + 1'b1;
         else if (pop && !push) count <= count - 1'b1;
      end
   end

   assign head  = ids[rd_ptr];
   assign empty = (count == '0);
   assign full  = (count == (LOG_DEPTH+1)'(DEPTH));

endmodule

// ==== hdl/ro_req_split.sv ====
`timescale 1ns/10ps

module ro_req_split (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  req_valid,
   output logic                  req_ready,
   input  task_pkg::ro_req_t     req,
   input  task_pkg::thread_id_t  thread_head,
   input  logic                  thread_empty,
   output logic                  thread_pop,
   output logic                  ctx_wr,
   output task_pkg::thread_id_t  ctx_thread,
   output task_pkg::thread_ctx_t ctx,
   output logic                  arvalid,
   input  logic                  arready,
   output mem_pkg::mem_ar_t      ar,
   input  mem_pkg::mem_id_t      id_head,
   input  logic                  id_empty,
   output logic                  mshr_wr,
   output task_pkg::ro_mshr_t    mshr
);

   import mem_pkg::*;
   import task_pkg::*;

   logic       busy;       // burst in progress
   addr_t      addr_q;
   n_words_t   n_left;
   n_words_t   start_word;
   thread_id_t thread_q;

   word_idx_t  offset;
   n_words_t   room;
   n_words_t   words_sent;
   n_words_t   line_end;
   word_mask_t mask;
   logic       last_line;
   logic       ar_fire;
   logic       req_fire;

   always_comb begin
      offset     = addr_q[5:2];
      room       = n_words_t'(LINE_WORDS) - n_words_t'(offset);
      words_sent = (n_left < room) ? n_left : room;
      last_line  = (n_left <= room);
      line_end   = n_words_t'(offset) + words_sent;
      for (int i = 0; i < LINE_WORDS; i++) begin
         mask[i] = (n_words_t'(i) >= n_words_t'(offset)) && (n_words_t'(i) < line_end);
      end
   end

   assign arvalid   = busy & !id_empty; // no read without a free id
   assign ar.addr   = addr_q;
   assign ar.id     = id_head;
   assign ar_fire   = arvalid & arready;

   // next burst may start while the final line of this one goes out
   assign req_ready = !thread_empty & (!busy | (ar_fire & last_line));
   assign req_fire  = req_valid & req_ready;

   assign thread_pop  = req_fire;
   assign ctx_wr      = req_fire;
   assign ctx_thread  = thread_head;
   assign ctx.tag     = req.tag;
   assign ctx.n_words = req.n_words;

   assign mshr_wr            = ar_fire;
   assign mshr.thread        = thread_q;
   assign mshr.valid_words   = mask;
   assign mshr.start_word_id = start_word;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (req_fire) begin
         busy <= 1'b1;
      end else if (ar_fire && last_line) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (req_fire) begin
         addr_q     <= req.addr;
         n_left     <= req.n_words;
         start_word <= '0;
         thread_q   <= thread_head;
      end else if (ar_fire) begin
         addr_q     <= {addr_q[31:6] + 26'd1, 6'd0}; // next line base
         n_left     <= n_left - words_sent;
         start_word <= start_word + words_sent;
      end
   end

endmodule

// ==== hdl/ro_resp_unpack.sv ====
`timescale 1ns/10ps

module ro_resp_unpack #(
   parameter int LOG_ARIDS = 3
) (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  mshr_wr,
   input  mem_pkg::mem_id_t      mshr_id,
   input  task_pkg::ro_mshr_t    mshr,
   input  logic                  ctx_wr,
   input  task_pkg::thread_id_t  ctx_thread,
   input  task_pkg::thread_ctx_t ctx,
   input  logic                  rvalid,
   output logic                  rready,
   input  mem_pkg::mem_r_t       r,
   output logic                  id_push,
   output mem_pkg::mem_id_t      id_push_id,
   output logic                  thread_push,
   output task_pkg::thread_id_t  thread_push_id,
   output logic                  out_valid,
   input  logic                  out_ready,
   output task_pkg::out_word_t   out
);

   import mem_pkg::*;
   import task_pkg::*;

   ro_mshr_t  mshr_tab [2**LOG_ARIDS];
   task_tag_t tag_tab [N_THREADS];
   n_words_t  remaining [N_THREADS]; // words still owed to each thread

   logic       held;
   line_t      line_q;
   word_mask_t mask_q;
   thread_id_t thread_q;
   n_words_t   word_id_q;

   word_idx_t  idx;
   word_mask_t next_mask;
   logic       deliver;
   logic       line_done;
   logic       r_fire;
   ro_mshr_t   r_entry;

   always_ff @(posedge clk) begin
      if (mshr_wr) mshr_tab[mshr_id[LOG_ARIDS-1:0]] <= mshr;
   end

   // lowest valid word of the held line
   always_comb begin
      idx = '0;
      for (int i = LINE_WORDS - 1; i >= 0; i--) begin
         if (mask_q[i]) idx = word_idx_t'(i);
      end
      next_mask      = mask_q;
      next_mask[idx] = 1'b0;
   end

   assign out_valid = held;
   assign deliver   = out_valid & out_ready;
   assign line_done = (next_mask == '0);

   assign out.tag     = tag_tab[thread_q];
   assign out.word_id = word_id_q;
   assign out.data    = line_q[idx*32 +: 32];
   assign out.last    = (remaining[thread_q] == n_words_t'(1));

   assign rready  = !held | (deliver & line_done);
   assign r_fire  = rvalid & rready;
   assign r_entry = mshr_tab[r.id[LOG_ARIDS-1:0]];

   assign id_push        = r_fire; // id is free once its line is taken
   assign id_push_id     = r.id;
   assign thread_push    = deliver & out.last;
   assign thread_push_id = thread_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         held <= 1'b0;
      end else if (r_fire) begin
         held <= 1'b1;
      end else if (deliver && line_done) begin
         held <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (r_fire) begin
         line_q    <= r.data;
         mask_q    <= r_entry.valid_words;
         thread_q  <= r_entry.thread;
         word_id_q <= r_entry.start_word_id;
      end else if (deliver) begin
         mask_q    <= next_mask;
         word_id_q <= word_id_q + 1'b1;
      end
   end

   // a thread being allocated is never the one delivering
   always_ff @(posedge clk) begin
      if (ctx_wr) begin
         tag_tab[ctx_thread]   <= ctx.tag;
         remaining[ctx_thread] <= ctx.n_words;
      end
      if (deliver) remaining[thread_q] <= remaining[thread_q] - 1'b1;
   end

endmodule

// ==== hdl/read_only_stage.sv ====
`timescale 1ns/10ps

module read_only_stage #(
   parameter int LOG_ARIDS = 3
) (
   input  logic                clk,
   input  logic                rstn,
   input  logic                req_valid,
   output logic                req_ready,
   input  task_pkg::ro_req_t   req,
   output logic                arvalid,
   input  logic                arready,
   output mem_pkg::mem_ar_t    ar,
   input  logic                rvalid,
   output logic                rready,
   input  mem_pkg::mem_r_t     r,
   output logic                out_valid,
   input  logic                out_ready,
   output task_pkg::out_word_t out,
   output logic                idle
);

   import mem_pkg::*;
   import task_pkg::*;

   logic [LOG_ARIDS-1:0] arid_head;
   logic                 arid_empty;
   mem_id_t              id_head;
   logic                 id_push;
   mem_id_t              id_push_id;

   thread_id_t  thread_head;
   logic        thread_empty;
   logic        thread_pop;
   logic        thread_push;
   thread_id_t  thread_push_id;

   logic        ctx_wr;
   thread_id_t  ctx_thread;
   thread_ctx_t ctx;
   logic        mshr_wr;
   ro_mshr_t    mshr;

   assign id_head = mem_id_t'(arid_head); // pool ids widened to the bus id

   ro_free_list #(
      .LOG_DEPTH(LOG_ARIDS)
   ) arid_pool (
      .clk(clk), .rstn(rstn),
      .push(id_push), .push_id(id_push_id[LOG_ARIDS-1:0]),
      .pop(mshr_wr), .head(arid_head),
      .empty(arid_empty), .full()
   );

   ro_free_list #(
      .LOG_DEPTH(LOG_THREADS)
   ) thread_pool (
      .clk(clk), .rstn(rstn),
      .push(thread_push), .push_id(thread_push_id),
      .pop(thread_pop), .head(thread_head),
      .empty(thread_empty), .full(idle) // every thread back home
   );

   ro_req_split split (
      .clk(clk), .rstn(rstn),
      .req_valid(req_valid), .req_ready(req_ready), .req(req),
      .thread_head(thread_head), .thread_empty(thread_empty), .thread_pop(thread_pop),
      .ctx_wr(ctx_wr), .ctx_thread(ctx_thread), .ctx(ctx),
      .arvalid(arvalid), .arready(arready), .ar(ar),
      .id_head(id_head), .id_empty(arid_empty),
      .mshr_wr(mshr_wr), .mshr(mshr)
   );

   ro_resp_unpack #(
      .LOG_ARIDS(LOG_ARIDS)
   ) unpack (
      .clk(clk), .rstn(rstn),
      .mshr_wr(mshr_wr), .mshr_id(ar.id), .mshr(mshr),
      .ctx_wr(ctx_wr), .ctx_thread(ctx_thread), .ctx(ctx),
      .rvalid(rvalid), .rready(rready), .r(r),
      .id_push(id_push), .id_push_id(id_push_id),
      .thread_push(thread_push), .thread_push_id(thread_push_id),
      .out_valid(out_valid), .out_ready(out_ready), .out(out)
   );

endmodule

// ==== testbench/read_only_stage_chk.sv ====
`timescale 1ns/10ps

module read_only_stage_chk (
   input logic                clk,
   input logic                rstn,
   input logic                req_valid,
   input logic                req_ready,
   input logic                idle,
   input logic                arvalid,
   input logic                arready,
   input mem_pkg::mem_ar_t    ar,
   input logic                out_valid,
   input logic                out_ready,
   input task_pkg::out_word_t out
);

   import task_pkg::*;

   logic                 req_fire;
   logic                 req_done;
   logic [LOG_THREADS:0] taken; // requests accepted and not yet finished

   assign req_fire = req_valid & req_ready;
   assign req_done = out_valid & out_ready & out.last;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         taken <= '0;
      end else begin
         taken <= taken + (LOG_THREADS+1)'(req_fire) - (LOG_THREADS+1)'(req_done);
      end
   end

   ar_hold: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(ar))
      else $error("ar dropped or changed while stalled");

   out_hold: assert property (@(posedge clk) disable iff (!rstn)
      out_valid && !out_ready |=> out_valid && $stable(out))
      else $error("out dropped or changed while stalled");

   // all four threads taken
   no_thread_ready: assert property (@(posedge clk) disable iff (!rstn)
      !idle && taken == (LOG_THREADS+1)'(N_THREADS) |-> !req_ready)
      else $error("req_ready high with no free thread");

endmodule

bind read_only_stage read_only_stage_chk read_only_stage_chk_inst (.*);

// ==== testbench/tb_read_only_stage.sv ====
`timescale 1ns/10ps

module tb_read_only_stage;

   import mem_pkg::*;
   import task_pkg::*;

   localparam int LOG_ARIDS = 3;
   localparam int MAX_CASES = 64;

   logic      clk;
   logic      rstn;
   logic      req_valid;
   logic      req_ready;
   ro_req_t   req;
   logic      arvalid;
   logic      arready;
   mem_ar_t   ar;
   logic      rvalid;
   logic      rready;
   mem_r_t    r;
   logic      out_valid;
   logic      out_ready;
   out_word_t out;
   logic      idle;

   task_tag_t c_tag [MAX_CASES];
   addr_t     c_addr [MAX_CASES];
   int        c_words [MAX_CASES];
   int        c_ar_pct [MAX_CASES];
   int        c_out_pct [MAX_CASES];
   int        c_dly [MAX_CASES];
   int        n_cases;

   int        ar_pct = 100;
   int        out_pct = 100;
   int        r_dly = 0;
   int        in_flight = 0;  // requests accepted and not yet finished
   int        cycles;
   int        limit = 0;
   out_word_t exp_q [$];
   addr_t     exp_ar_q [$];
   addr_t     mem_addr_q [$];  // reads waiting in the memory model
   mem_id_t   mem_id_q [$];
   int        mem_dly_q [$];
   bit        id_busy [256];

   read_only_stage #(
      .LOG_ARIDS(LOG_ARIDS)
   ) read_only_stage_inst (
      .clk(clk), .rstn(rstn),
      .req_valid(req_valid), .req_ready(req_ready), .req(req),
      .arvalid(arvalid), .arready(arready), .ar(ar),
      .rvalid(rvalid), .rready(rready), .r(r),
      .out_valid(out_valid), .out_ready(out_ready), .out(out),
      .idle(idle)
   );

   task automatic fail_run(string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
      end
   endtask

   // word k of a line holds its own byte address
   function automatic line_t make_line(addr_t a);
      line_t l;
      addr_t base;
      base = {a[31:6], 6'd0};
      for (int k = 0; k < LINE_WORDS; k++) begin
         l[k*32 +: 32] = base + addr_t'(4*k);
      end
      return l;
   endfunction

   task automatic load_stimulus();
      int          fd;
      int          n;
      string       line;
      logic [31:0] tag;
      logic [31:0] addr;
      int          words;
      int          ap;
      int          op;
      int          dl;
      n_cases = 0;
      fd = $fopen("testbench/ro_cases.mem", "r");
      if (fd == 0) begin
         fail_run("could not open the cases file testbench/ro_cases.mem");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() >= 2 && line.substr(0, 1) != "//") begin
               n = $sscanf(line, "%h %h %d %d %d %d", tag, addr, words, ap, op, dl);
               if (n == 6 && n_cases < MAX_CASES) begin
                  if (words < 1 || words > 64) fail_run("a case asks for an illegal word count");
                  c_tag[n_cases]     = task_tag_t'(tag);
                  c_addr[n_cases]    = addr;
                  c_words[n_cases]   = words;
                  c_ar_pct[n_cases]  = ap;
                  c_out_pct[n_cases] = op;
                  c_dly[n_cases]     = dl;
                  limit = limit + 50 * words;
                  n_cases++;
               end
            end
         end
         $fclose(fd);
         limit = limit + 200;
      end
   endtask

   task automatic queue_expected();
      out_word_t w;
      addr_t     a;
      int        n;
      int        left;
      n = int'(req.n_words);
      for (int i = 0; i < n; i++) begin
         w.tag     = req.tag;
         w.word_id = n_words_t'(i);
         w.data    = req.addr + addr_t'(4*i);
         w.last    = (i == n - 1);
         exp_q.push_back(w);
      end
      a    = req.addr;
      left = n;
      do begin  // one read per line touched
         exp_ar_q.push_back(a);
         left = left - (16 - int'(a[5:2]));
         a    = (a & ~addr_t'(63)) + addr_t'(64);
      end while (left > 0);
      in_flight++;
   endtask

   task automatic track_read();
      if (exp_ar_q.size() == 0) fail_run("a read was issued with no request line left to read");
      check_value("ar.addr", 64'(ar.addr), 64'(exp_ar_q.pop_front()));
      if (id_busy[ar.id]) fail_run($sformatf("read id %0h reused while outstanding", ar.id));
      id_busy[ar.id] = 1'b1;
      mem_addr_q.push_back(ar.addr);
      mem_id_q.push_back(ar.id);
      mem_dly_q.push_back(r_dly);
   endtask

   task automatic compare_word();
      out_word_t exp;
      if (exp_q.size() == 0) fail_run("an output word came out that no request asked for");
      exp = exp_q.pop_front();
      check_value("out.data", 64'(out.data), 64'(exp.data));
      check_value("out.tag", 64'(out.tag), 64'(exp.tag));
      check_value("out.word_id", 64'(out.word_id), 64'(exp.word_id));
      check_value("out.last", 64'(out.last), 64'(exp.last));
      if (exp.last) in_flight--;
   endtask

   initial begin : clock_gen
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // handshakes sampled mid-cycle once everything has settled
   always @(negedge clk) begin
      if (rstn) begin
         if (in_flight == N_THREADS) check_value("req_ready", 64'(req_ready), 64'(0));
         if (req_valid && req_ready) queue_expected();
         if (arvalid && arready) track_read();
         if (rvalid && rready) id_busy[r.id] = 1'b0;
         if (out_valid && out_ready) compare_word();
      end
   end

   initial begin : stall_drive
      forever begin
         @(posedge clk);
         #1;
         arready   = int'($urandom % 100) < ar_pct;
         out_ready = int'($urandom % 100) < out_pct;
      end
   end

   initial begin : mem_return
      int      dly;
      addr_t   a;
      mem_id_t id;
      forever begin
         @(posedge clk);
         if (mem_addr_q.size() != 0) begin
            a   = mem_addr_q.pop_front();
            id  = mem_id_q.pop_front();
            dly = mem_dly_q.pop_front();
            repeat (dly) @(posedge clk);
            #1;
            rvalid = 1'b1;
            r.id   = id;
            r.data = make_line(a);
            do @(negedge clk); while (!rready);
            @(posedge clk);
            #1;
            rvalid = 1'b0;
         end
      end
   end

   initial begin : watchdog
      cycles = 0;
      forever begin
         @(posedge clk);
         cycles++;
         if (limit > 0 && cycles > limit) fail_run($sformatf("timeout after %0d cycles", cycles));
      end
   end

   initial begin : main
      void'($urandom(32'h7bb8_c5dd));
      rstn      = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      arready   = 1'b0;
      rvalid    = 1'b0;
      r         = '0;
      out_ready = 1'b0;
      load_stimulus();
      repeat (3) @(posedge clk);
      #1;
      rstn = 1'b1;
      @(negedge clk);
      check_value("arvalid", 64'(arvalid), 64'(0));
      check_value("out_valid", 64'(out_valid), 64'(0));
      check_value("req_ready", 64'(req_ready), 64'(1));
      check_value("idle", 64'(idle), 64'(1));
      check_value("rready", 64'(rready), 64'(1));
      for (int i = 0; i < n_cases; i++) begin
         @(posedge clk);
         #1;
         ar_pct        = c_ar_pct[i];
         out_pct       = c_out_pct[i];
         r_dly         = c_dly[i];
         req_valid     = 1'b1;
         req.tag       = c_tag[i];
         req.addr      = c_addr[i];
         req.n_words   = n_words_t'(c_words[i]);
         do @(negedge clk); while (!req_ready);
      end
      @(posedge clk);
      #1;
      req_valid = 1'b0;
      while (exp_q.size() != 0) @(negedge clk);
      @(negedge clk);  // last thread is back in the pool by now
      check_value("idle", 64'(idle), 64'(1));
      check_value("reads still expected", 64'(exp_ar_q.size()), 64'(0));
      $display(">>> PASS");
      $finish;
   end

endmodule

// ==== testbench/ro_cases.mem ====
// tag addr n_words ar_pct out_pct r_delay
// tag and addr in hex, the other columns in decimal
01 00001000 4 100 100 0
02 00001034 3 100 100 0
03 0000203c 5 100 100 1
04 00003008 40 100 100 0
05 00004000 64 100 100 2
06 00005004 64 100 100 0
10 00006010 20 50 50 2
11 0000707c 17 30 70 5
12 00008020 33 60 40 0
13 00009ffc 2 40 60 3
20 0000a000 16 100 10 0
21 0000b008 16 100 10 0
22 0000c010 16 100 10 0
23 0000d018 16 100 10 0
24 0000e000 12 100 10 0
30 0000f040 1 20 20 8
31 00010004 60 70 80 1

// ==== read_only_stage.f ====
hdl/mem_pkg.sv
hdl/task_pkg.sv
hdl/ro_free_list.sv
hdl/ro_req_split.sv
hdl/ro_resp_unpack.sv
hdl/read_only_stage.sv
testbench/read_only_stage_chk.sv
testbench/tb_read_only_stage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module tb_read_only_stage -f read_only_stage.f
out=$(./obj_dir/Vtb_read_only_stage) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '>>> PASS'
